//--- rtl/mem_pkg.sv
/*
 * shared types for the data memory
 * access size encoding, register and lane data, byte strobes
 * and the lane count of one storage row
 */

package mem_pkg;

    // lanes in one row, fixed by the 64-bit register width
    localparam int NUM_LANES = 8;

    // access size as decoded from the load/store funct3
    typedef enum logic [1:0] {
        WIDTH_BYTE   = 2'b00,
        WIDTH_HALF   = 2'b01,
        WIDTH_WORD   = 2'b10,
        WIDTH_DOUBLE = 2'b11
    } access_width_t;

    // one register value, also one full storage row
    typedef logic [63:0] data_t;

    // contents of a single byte lane
    typedef logic [7:0] byte_t;

    // one enable bit per byte lane
    typedef logic [NUM_LANES-1:0] strobe_t;

    // byte position inside a row, the low address bits
    typedef logic [2:0] lane_sel_t;

endpackage

//--- rtl/mem_lane_if.sv
/*
 * per-row request as seen by the byte banks and the load path
 * driven by the request steering
 */

interface mem_lane_if import mem_pkg::*; #(
    parameter int ROW_W = 10
) ();

    logic [ROW_W-1:0] row;
    data_t            lane_wdata;
    strobe_t          wstrb;
    logic             ren;
    lane_sel_t        offset;
    access_width_t    width;
    logic             is_unsigned;

    modport steer (
        output row, lane_wdata, wstrb, ren, offset, width, is_unsigned
    );

    // storage only needs the row, lane data and enables
    modport bank (
        input row, lane_wdata, wstrb, ren
    );

    // load path needs the attributes of the read
    modport extract (
        input ren, offset, width, is_unsigned
    );

endinterface

//--- rtl/req_steer.sv
/*
 * request side of the data memory
 * window and alignment check, registered fault flag,
 * row index, lane-shifted store data and byte strobes
 */

module req_steer import mem_pkg::*; #(
    parameter int                ADDR_W    = 16,
    parameter logic [ADDR_W-1:0] BASE_ADDR = 16'h8000,
    parameter int                ROW_W     = 10
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              ren,
    input  logic              wen,
    input  logic [ADDR_W-1:0] addr,
    input  access_width_t     width,
    input  logic              is_unsigned,
    input  data_t             wdata,
    output logic              fault,
    mem_lane_if.steer         lane
);

    // bytes covered by the window, one bit wider than the address
    localparam logic [ADDR_W:0] WINDOW_BYTES = (ADDR_W + 1)'(1) << (ROW_W + 3);

    logic [ADDR_W-1:0] offset_addr;
    lane_sel_t         lane_sel;
    logic              in_window;
    logic              misaligned;
    logic              bad;
    logic              good;
    strobe_t           base_strb;

    assign offset_addr = addr - BASE_ADDR;
    assign lane_sel    = offset_addr[2:0];

    // below base wraps around, so check both ends
    assign in_window = (addr >= BASE_ADDR) && ({1'b0, offset_addr} < WINDOW_BYTES);

    always_comb begin
        case (width)
            WIDTH_BYTE: begin
                misaligned = 1'b0;
                base_strb  = 8'h01;
            end
            WIDTH_HALF: begin
                misaligned = lane_sel[0];
                base_strb  = 8'h03;
            end
            WIDTH_WORD: begin
                misaligned = |lane_sel[1:0];
                base_strb  = 8'h0f;
            end
            default: begin
                misaligned = |lane_sel;
                base_strb  = 8'hff;
            end
        endcase
    end

    assign bad  = (ren | wen) & (misaligned | ~in_window);
    assign good = ~bad;

    // bad requests never reach the banks
    assign lane.row         = offset_addr[ROW_W+2:3];
    assign lane.lane_wdata  = wdata << {lane_sel, 3'b000};
    assign lane.wstrb       = (wen & good) ? strobe_t'(base_strb << lane_sel) : '0;
    assign lane.ren         = ren & good;
    assign lane.offset      = lane_sel;
    assign lane.width       = width;
    assign lane.is_unsigned = is_unsigned;

    always_ff @(posedge clk) begin
        if (rst) begin
            fault <= 1'b0;
        end else begin
            fault <= bad;
        end
    end

endmodule

//--- rtl/byte_bank.sv
/*
 * one byte lane of data memory storage
 * strobed synchronous write, registered read
 */

module byte_bank import mem_pkg::*; #(
    parameter int ROW_W = 10,
    parameter int LANE  = 0
) (
    input  logic     clk,
    input  logic     lane_en,
    mem_lane_if.bank lane,
    output byte_t    rdata
);

    localparam int DEPTH = 2 ** ROW_W;

    byte_t mem [DEPTH];
    byte_t wr_byte;

    // this lane's slice of the steered store data
    assign wr_byte = lane.lane_wdata[LANE*8 +: 8];

    // reads and writes never share a cycle, so no bypass needed
    always_ff @(posedge clk) begin
        if (lane_en) begin
            mem[lane.row] <= wr_byte;
        end
        if (lane.ren) begin
            rdata <= mem[lane.row];
        end
    end

endmodule

//--- rtl/load_extract.sv
/*
 * load side of the data memory
 * captures offset, size and signedness of each good read,
 * then selects and extends the addressed bytes of the row
 */

module load_extract import mem_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    mem_lane_if.extract lane,
    input  data_t       row_data,
    output data_t       rdata
);

    lane_sel_t     offset_q;
    access_width_t width_q;
    logic          unsigned_q;
    logic          have_data;
    data_t         shifted;
    logic          sign;
    data_t         result;

    // attributes of the read that is now in the bank registers
    always_ff @(posedge clk) begin
        if (rst) begin
            offset_q   <= '0;
            width_q    <= WIDTH_DOUBLE;
            unsigned_q <= 1'b0;
            have_data  <= 1'b0;
        end else if (lane.ren) begin
            offset_q   <= lane.offset;
            width_q    <= lane.width;
            unsigned_q <= lane.is_unsigned;
            have_data  <= 1'b1;
        end
    end

    // addressed bytes down to lane 0
    assign shifted = row_data >> {offset_q, 3'b000};

    always_comb begin
        case (width_q)
            WIDTH_BYTE: begin
                sign   = shifted[7] & ~unsigned_q;
                result = {{56{sign}}, shifted[7:0]};
            end
            WIDTH_HALF: begin
                sign   = shifted[15] & ~unsigned_q;
                result = {{48{sign}}, shifted[15:0]};
            end
            WIDTH_WORD: begin
                sign   = shifted[31] & ~unsigned_q;
                result = {{32{sign}}, shifted[31:0]};
            end
            default: begin
                // ld needs no extension
                sign   = 1'b0;
                result = shifted;
            end
        endcase
    end

    // bank registers hold between reads, so the result holds too
    // zero until the first read after reset
    assign rdata = have_data ? result : '0;

endmodule

//--- rtl/data_mem.sv
/*
 * data memory for the 64-bit core
 * request steering, eight byte-lane banks and the load extractor
 */

module data_mem import mem_pkg::*; #(
    parameter int                ADDR_W    = 16,
    parameter logic [ADDR_W-1:0] BASE_ADDR = 16'h8000,
    parameter int                ROW_W     = 10
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              mem_ren,
    input  logic              mem_wen,
    input  logic [ADDR_W-1:0] mem_addr,
    input  access_width_t     mem_width,
    input  logic              mem_unsigned,
    input  data_t             mem_wdata,
    output data_t             mem_rdata,
    output logic              mem_fault
);

    // row as read out of the banks, lane i in bits 8i+7:8i
    data_t row_data;

    mem_lane_if #(
        .ROW_W(ROW_W)
    ) lane ();

    req_steer #(
        .ADDR_W   (ADDR_W),
        .BASE_ADDR(BASE_ADDR),
        .ROW_W    (ROW_W)
    ) u_req_steer (
        .clk        (clk),
        .rst        (rst),
        .ren        (mem_ren),
        .wen        (mem_wen),
        .addr       (mem_addr),
        .width      (mem_width),
        .is_unsigned(mem_unsigned),
        .wdata      (mem_wdata),
        .fault      (mem_fault),
        .lane       (lane.steer)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_bank
        byte_bank #(
            .ROW_W(ROW_W),
            .LANE (i)
        ) u_byte_bank (
            .clk    (clk),
            .lane_en(lane.wstrb[i]),
            .lane   (lane.bank),
            .rdata  (row_data[i*8 +: 8])
        );
    end

    load_extract u_load_extract (
        .clk     (clk),
        .rst     (rst),
        .lane    (lane.extract),
        .row_data(row_data),
        .rdata   (mem_rdata)
    );

endmodule

//--- tests/tb_data_mem.sv
/*
 * testbench for the data memory
 * byte-array reference model of the window, directed tests,
 * one compare task and a watchdog
 */

module tb_data_mem import mem_pkg::*; ();

    localparam int ADDR_W = 16;
    localparam int ROW_W = 10;
    localparam int CLK_PERIOD = 100;
    localparam int WIN_BYTES = 1 << (ROW_W + 3);

    typedef logic [ADDR_W-1:0] addr_t;

    localparam addr_t BASE_ADDR = 16'h8000;

    // rough cycle budget of each test
    localparam int CYC_RESET = 4;
    localparam int CYC_DOUBLE = 16;
    localparam int CYC_PARTIAL = 56;
    localparam int CYC_EXTEND = 120;
    localparam int CYC_FAULT = 40;
    localparam int CYC_B2B = 24;
    localparam int CYC_RERESET = 16;
    localparam int CYC_MARGIN = 100;
    localparam int RUN_CYCLES = CYC_RESET + CYC_DOUBLE + CYC_PARTIAL + CYC_EXTEND
                              + CYC_FAULT + CYC_B2B + CYC_RERESET + CYC_MARGIN;

    logic          clk;
    logic          rst;
    logic          mem_ren;
    logic          mem_wen;
    addr_t         mem_addr;
    access_width_t mem_width;
    logic          mem_unsigned;
    data_t         mem_wdata;
    data_t         mem_rdata;
    logic          mem_fault;

    // reference copy of the window, index is address minus base
    byte_t model [WIN_BYTES];

    integer seed = 32'hd8fc;
    string  cur_test;
    int     test_errs;
    int     pass_tests;
    int     fail_tests;

    data_mem #(
        .ADDR_W   (ADDR_W),
        .BASE_ADDR(BASE_ADDR),
        .ROW_W    (ROW_W)
    ) UUT (
        .clk         (clk),
        .rst         (rst),
        .mem_ren     (mem_ren),
        .mem_wen     (mem_wen),
        .mem_addr    (mem_addr),
        .mem_width   (mem_width),
        .mem_unsigned(mem_unsigned),
        .mem_wdata   (mem_wdata),
        .mem_rdata   (mem_rdata),
        .mem_fault   (mem_fault)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(RUN_CYCLES * CLK_PERIOD);
        $display("watchdog expired, the tests did not finish in time");
        $display("** FAIL **");
        $finish;
    end

    function automatic data_t rand64();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic int size_bytes(access_width_t w);
        case (w)
            WIDTH_BYTE: return 1;
            WIDTH_HALF: return 2;
            WIDTH_WORD: return 4;
            default:    return 8;
        endcase
    endfunction

    function automatic access_width_t narrow_width(int i);
        case (i)
            0:       return WIDTH_BYTE;
            1:       return WIDTH_HALF;
            default: return WIDTH_WORD;
        endcase
    endfunction

    function automatic addr_t at(int off);
        return addr_t'(int'(BASE_ADDR) + off);
    endfunction

    // inside the window and naturally aligned
    function automatic logic legal(addr_t a, access_width_t w);
        int idx;
        idx = int'(a) - int'(BASE_ADDR);
        return (idx >= 0) && (idx < WIN_BYTES) && (idx % size_bytes(w) == 0);
    endfunction

    // little endian, lowest address in the low byte
    function automatic void model_write(addr_t a, access_width_t w, data_t d);
        int idx;
        idx = int'(a) - int'(BASE_ADDR);
        for (int i = 0; i < size_bytes(w); i++) begin
            model[idx + i] = d[8*i +: 8];
        end
    endfunction

    function automatic data_t model_read(addr_t a, access_width_t w, logic uns);
        int    idx;
        int    n;
        data_t v;
        idx = int'(a) - int'(BASE_ADDR);
        n = size_bytes(w);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[8*i +: 8] = model[idx + i];
        end
        if (!uns && v[8*n-1]) begin
            for (int j = 8 * n; j < 64; j++) begin
                v[j] = 1'b1;
            end
        end
        return v;
    endfunction

    task automatic check(input string what, input data_t exp, input data_t act);
        if (exp !== act) begin
            $display("ERR %s %s: expected %h, actual %h", cur_test, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        if (test_errs == 0) begin
            pass_tests++;
            $display("test %s finished, no errors", cur_test);
        end else begin
            fail_tests++;
            $display("test %s finished, %0d errors", cur_test, test_errs);
        end
    endtask

    task automatic drive_idle();
        mem_ren <= 1'b0;
        mem_wen <= 1'b0;
    endtask

    task automatic put_req(input logic rd, input logic wr, input addr_t a,
                           input access_width_t w, input logic uns, input data_t d);
        mem_ren      <= rd;
        mem_wen      <= wr;
        mem_addr     <= a;
        mem_width    <= w;
        mem_unsigned <= uns;
        mem_wdata    <= d;
    endtask

    // request inputs stay as they are while reset is held
    task automatic hold_reset();
        rst <= 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        drive_idle();
    endtask

    task automatic store(input addr_t a, input access_width_t w, input data_t d);
        logic ok;
        ok = legal(a, w);
        @(posedge clk);
        put_req(1'b0, 1'b1, a, w, 1'b0, d);
        @(posedge clk);
        drive_idle();
        if (ok) begin
            model_write(a, w, d);
        end
        @(negedge clk);
        check("store fault", data_t'(!ok), data_t'(mem_fault));
    endtask

    task automatic load(input addr_t a, input access_width_t w, input logic uns);
        logic ok;
        ok = legal(a, w);
        @(posedge clk);
        put_req(1'b1, 1'b0, a, w, uns, '0);
        @(posedge clk);
        drive_idle();
        @(negedge clk);
        check("load fault", data_t'(!ok), data_t'(mem_fault));
        if (ok) begin
            check($sformatf("load %h", a), model_read(a, w, uns), mem_rdata);
        end
    endtask

    task automatic test_reset_state();
        start_test("reset_state");
        @(negedge clk);
        check("fault", '0, data_t'(mem_fault));
        check("rdata", '0, mem_rdata);
        end_test();
    endtask

    task automatic test_double();
        int offs [4];
        offs = '{0, 'h48, 'h1000, WIN_BYTES - 8};
        start_test("double_store_load");
        for (int k = 0; k < 4; k++) begin
            store(at(offs[k]), WIDTH_DOUBLE, rand64());
            load(at(offs[k]), WIDTH_DOUBLE, 1'b0);
        end
        end_test();
    endtask

    task automatic test_partial();
        start_test("partial_stores");
        store(at('h100), WIDTH_DOUBLE, rand64());
        for (int off = 0; off < 8; off++) begin
            store(at('h100 + off), WIDTH_BYTE, rand64());
            load(at('h100), WIDTH_DOUBLE, 1'b0);
        end
        for (int off = 0; off < 8; off += 2) begin
            store(at('h100 + off), WIDTH_HALF, rand64());
            load(at('h100), WIDTH_DOUBLE, 1'b0);
        end
        end_test();
    endtask

    task automatic test_extend();
        access_width_t w;
        data_t         d;
        start_test("extend_loads");
        // first pass with every sign bit set, second with none
        for (int pass = 0; pass < 2; pass++) begin
            d = rand64();
            d = (pass == 0) ? (d | 64'h8080_8080_8080_8080) : (d & 64'h7f7f_7f7f_7f7f_7f7f);
            store(at('h300), WIDTH_DOUBLE, d);
            for (int wi = 0; wi < 3; wi++) begin
                w = narrow_width(wi);
                for (int off = 0; off < 8; off += size_bytes(w)) begin
                    load(at('h300 + off), w, 1'b0);
                    load(at('h300 + off), w, 1'b1);
                end
            end
        end
        end_test();
    endtask

    task automatic test_faults();
        start_test("faults");
        store(at('h400), WIDTH_DOUBLE, rand64());
        store(at(0), WIDTH_DOUBLE, rand64());
        store(at(WIN_BYTES - 8), WIDTH_DOUBLE, rand64());
        load(at('h401), WIDTH_HALF, 1'b0);
        load(at('h402), WIDTH_WORD, 1'b0);
        load(at('h406), WIDTH_WORD, 1'b1);
        load(at('h404), WIDTH_DOUBLE, 1'b0);
        store(at('h403), WIDTH_HALF, rand64());
        store(at('h402), WIDTH_WORD, rand64());
        store(at('h404), WIDTH_DOUBLE, rand64());
        // just below and just past the window
        store(at(-8), WIDTH_DOUBLE, rand64());
        store(at(WIN_BYTES), WIDTH_DOUBLE, rand64());
        load(at(-1), WIDTH_BYTE, 1'b0);
        load(at(WIN_BYTES), WIDTH_DOUBLE, 1'b0);
        // rows that a leaked write would have hit
        load(at('h400), WIDTH_DOUBLE, 1'b0);
        load(at(0), WIDTH_DOUBLE, 1'b0);
        load(at(WIN_BYTES - 8), WIDTH_DOUBLE, 1'b0);
        end_test();
    endtask

    task automatic test_back_to_back();
        data_t d;
        start_test("back_to_back");
        for (int k = 0; k < 4; k++) begin
            store(at('h200 + 8 * k), WIDTH_DOUBLE, rand64());
        end
        @(posedge clk);
        put_req(1'b1, 1'b0, at('h200), WIDTH_DOUBLE, 1'b0, '0);
        for (int k = 1; k <= 4; k++) begin
            @(posedge clk);
            if (k < 4) begin
                put_req(1'b1, 1'b0, at('h200 + 8 * k), WIDTH_DOUBLE, 1'b0, '0);
            end else begin
                drive_idle();
            end
            @(negedge clk);
            check($sformatf("read %0d fault", k - 1), '0, data_t'(mem_fault));
            check($sformatf("read %0d", k - 1),
                  model_read(at('h200 + 8 * (k - 1)), WIDTH_DOUBLE, 1'b0), mem_rdata);
        end
        // store then load of the same row on the next cycle
        d = rand64();
        @(posedge clk);
        put_req(1'b0, 1'b1, at('h20c), WIDTH_WORD, 1'b0, d);
        @(posedge clk);
        put_req(1'b1, 1'b0, at('h208), WIDTH_DOUBLE, 1'b0, '0);
        model_write(at('h20c), WIDTH_WORD, d);
        @(posedge clk);
        drive_idle();
        @(negedge clk);
        check("read after store", model_read(at('h208), WIDTH_DOUBLE, 1'b0), mem_rdata);
        end_test();
    endtask

    task automatic test_rereset();
        start_test("reset_again");
        store(at('h500), WIDTH_DOUBLE, rand64() | 64'h1);
        load(at('h500), WIDTH_DOUBLE, 1'b0);
        load(at('h501), WIDTH_DOUBLE, 1'b0);
        // a misaligned read stays on the inputs for the whole reset
        @(posedge clk);
        put_req(1'b1, 1'b0, at('h501), WIDTH_DOUBLE, 1'b0, '0);
        hold_reset();
        @(negedge clk);
        check("fault", '0, data_t'(mem_fault));
        check("rdata", '0, mem_rdata);
        end_test();
    endtask

    initial begin
        rst = 1'b1;
        mem_ren = 1'b0;
        mem_wen = 1'b0;
        mem_addr = '0;
        mem_width = WIDTH_DOUBLE;
        mem_unsigned = 1'b0;
        mem_wdata = '0;
        pass_tests = 0;
        fail_tests = 0;
        hold_reset();
        test_reset_state();
        test_double();
        test_partial();
        test_extend();
        test_faults();
        test_back_to_back();
        test_rereset();
        $display("tests passed %0d, failed %0d", pass_tests, fail_tests);
        if (fail_tests == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- list.f
rtl/mem_pkg.sv
rtl/mem_lane_if.sv
rtl/req_steer.sv
rtl/byte_bank.sv
rtl/load_extract.sv
rtl/data_mem.sv
tests/tb_data_mem.sv

//--- Makefile
# Verilator build and run of the data memory testbench

VERILATOR ?= verilator
TOP       ?= tb_data_mem
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

SRCS := $(wildcard rtl/*.sv) $(wildcard tests/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the pass line shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf $(OBJ_DIR)
